/* snake_macros.svh */
`ifndef SNAKE_MACROS_SVH
`define SNAKE_MACROS_SVH

// snake size in segments
`define SNAKE_MAX_LEN   20
`define SNAKE_INIT_LEN  5

// playfield in signed cells, a head outside dies
`define FIELD_X_MIN     (-12)
`define FIELD_X_MAX     12
`define FIELD_Y_MIN     (-9)
`define FIELD_Y_MAX     7

// central square, inside when both coords strictly within +-OBST_HALF
`define OBST_HALF       2

// cycles between steps per speed select
`define STEP_PERIOD_0   24
`define STEP_PERIOD_1   16
`define STEP_PERIOD_2   12
`define STEP_PERIOD_3   8

`define FOOD_START_X    6
`define FOOD_START_Y    (-3)

`define LFSR_SEED       16'hace1

`endif

/* snake_pkg.sv */
`default_nettype none
`include "snake_macros.svh"

package snake_pkg;

    typedef logic signed [5:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } cell_t;

    typedef struct packed {
        logic left;
        logic right;
        logic up;
        logic down;
    } buttons_t;

    typedef enum logic [1:0] {
        HEAD_RIGHT,
        HEAD_LEFT,
        HEAD_UP,
        HEAD_DOWN
    } heading_t;

    typedef enum logic [1:0] {
        IDLE,
        PLAY,
        MOVE,
        OVER
    } phase_t;

    typedef cell_t [`SNAKE_MAX_LEN-1:0] body_t;   // index 0 is the head
    typedef logic [4:0] len_t;
    typedef logic [1:0] speed_t;

    function automatic logic out_of_field(cell_t c);
        return (c.x < `FIELD_X_MIN) || (c.x > `FIELD_X_MAX) ||
               (c.y < `FIELD_Y_MIN) || (c.y > `FIELD_Y_MAX);
    endfunction

    function automatic logic in_obstacle(cell_t c);
        return (c.x > -`OBST_HALF) && (c.x < `OBST_HALF) &&
               (c.y > -`OBST_HALF) && (c.y < `OBST_HALF);
    endfunction

    // match against active segments first..len-1
    function automatic logic hits_body(cell_t c, body_t b, len_t len, int first);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < `SNAKE_MAX_LEN; i++) begin
            if (i >= first && i < int'(len) && b[i] == c) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

endpackage

`default_nettype wire

/* step_timer.sv */
`timescale 1ns/1ns
`default_nettype none
`include "snake_macros.svh"

module step_timer import snake_pkg::*; (
    input  logic   CLK,
    input  logic   RESET,
    input  speed_t speed,
    input  logic   pause,
    output logic   step
);

    logic [4:0] cnt;
    logic [4:0] period;

    always_comb begin
        case (speed)
            2'd0:    period = 5'(`STEP_PERIOD_0);
            2'd1:    period = 5'(`STEP_PERIOD_1);
            2'd2:    period = 5'(`STEP_PERIOD_2);
            default: period = 5'(`STEP_PERIOD_3);
        endcase
    end

    // one pulse every period+1 cycles
    always_ff @(posedge CLK) begin
        if (RESET || pause) begin
            cnt  <= '0;
            step <= 1'b0;
        end else if (cnt >= period) begin
            cnt  <= '0;
            step <= 1'b1;
        end else begin
            cnt  <= cnt + 5'd1;
            step <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* direction_fsm.sv */
`timescale 1ns/1ns
`default_nettype none

module direction_fsm import snake_pkg::*; (
    input  logic     CLK,
    input  logic     RESET,
    input  logic     step,
    input  logic     dead,
    input  buttons_t buttons,
    output phase_t   phase,
    output heading_t heading
);

    heading_t turn;
    logic     any_press;

    assign any_press = |buttons;

    // right angles only, reversal is dropped
    always_comb begin
        turn = heading;
        case (heading)
            HEAD_RIGHT, HEAD_LEFT: begin
                if (buttons.up) begin
                    turn = HEAD_UP;
                end else if (buttons.down) begin
                    turn = HEAD_DOWN;
                end
            end
            default: begin
                if (buttons.left) begin
                    turn = HEAD_LEFT;
                end else if (buttons.right) begin
                    turn = HEAD_RIGHT;
                end
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            phase   <= IDLE;
            heading <= HEAD_RIGHT;
        end else begin
            case (phase)
                IDLE: begin
                    if (any_press) begin
                        phase <= PLAY;
                    end
                end
                PLAY: begin
                    if (dead) begin
                        phase <= OVER;
                    end else begin
                        if (step) begin
                            phase <= MOVE;
                        end
                        // snake faces right here, so left also means right
                        if (buttons.left || buttons.right) begin
                            heading <= HEAD_RIGHT;
                        end else if (buttons.up) begin
                            heading <= HEAD_UP;
                        end else if (buttons.down) begin
                            heading <= HEAD_DOWN;
                        end
                    end
                end
                MOVE: begin
                    if (dead) begin
                        phase <= OVER;
                    end else begin
                        heading <= turn;
                    end
                end
                default: ;   // OVER until reset
            endcase
        end
    end

endmodule

`default_nettype wire

/* snake_body.sv */
`timescale 1ns/1ns
`default_nettype none
`include "snake_macros.svh"

module snake_body import snake_pkg::*; (
    input  logic     CLK,
    input  logic     RESET,
    input  logic     step,
    input  logic     grow,
    input  phase_t   phase,
    input  heading_t heading,
    output cell_t    head,
    output body_t    body,
    output len_t     length
);

    localparam int START_Y = -3;
    localparam int TAIL0   = `SNAKE_INIT_LEN - 1;

    cell_t next_head;

    assign head = body[0];

    always_comb begin
        next_head = body[0];
        case (heading)
            HEAD_RIGHT: next_head.x = body[0].x + 6'sd1;
            HEAD_LEFT:  next_head.x = body[0].x - 6'sd1;
            HEAD_UP:    next_head.y = body[0].y + 6'sd1;
            default:    next_head.y = body[0].y - 6'sd1;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            // head at x=4, rest trailing left to x=0
            for (int i = 0; i < `SNAKE_MAX_LEN; i++) begin
                body[i].x <= (i < `SNAKE_INIT_LEN) ? coord_t'(TAIL0 - i) : '0;
                body[i].y <= coord_t'(START_Y);
            end
        end else if (step && phase == MOVE) begin
            body[0] <= next_head;
            for (int i = 1; i < `SNAKE_MAX_LEN; i++) begin
                if (i <= TAIL0 || i < int'(length)) begin
                    body[i] <= body[i-1];
                end else begin
                    body[i] <= body[TAIL0];   // parked on the vacated tail cell
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            length <= len_t'(`SNAKE_INIT_LEN);
        end else if (grow && length < len_t'(`SNAKE_MAX_LEN)) begin
            length <= length + 5'd1;
        end
    end

endmodule

`default_nettype wire

/* collision_check.sv */
`timescale 1ns/1ns
`default_nettype none

module collision_check import snake_pkg::*; (
    input  logic  CLK,
    input  logic  RESET,
    input  body_t body,
    input  len_t  length,
    output logic  dead
);

    cell_t hd;
    logic  hit_wall;
    logic  hit_obst;
    logic  hit_self;

    assign hd = body[0];

    always_comb begin
        hit_wall = out_of_field(hd);
        hit_obst = in_obstacle(hd);
        hit_self = hits_body(hd, body, length, 1);   // head itself excluded
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            dead <= 1'b0;
        end else begin
            dead <= hit_wall || hit_obst || hit_self;
        end
    end

endmodule

`default_nettype wire

/* food_placer.sv */
`timescale 1ns/1ns
`default_nettype none
`include "snake_macros.svh"

module food_placer import snake_pkg::*; (
    input  logic   CLK,
    input  logic   RESET,
    input  phase_t phase,
    input  body_t  body,
    input  len_t   length,
    output cell_t  food,
    output logic   grow
);

    localparam int FIELD_W = `FIELD_X_MAX - `FIELD_X_MIN + 1;
    localparam int FIELD_H = `FIELD_Y_MAX - `FIELD_Y_MIN + 1;

    logic [15:0] lfsr;
    logic        lfsr_fb;
    cell_t       rnd_cell;
    logic        eat;
    logic        food_bad;

    // x^16 + x^14 + x^13 + x^11 + 1
    assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    // fold lfsr halves into the field
    always_comb begin
        rnd_cell.x = coord_t'(`FIELD_X_MIN + int'(lfsr[7:0]) % FIELD_W);
        rnd_cell.y = coord_t'(`FIELD_Y_MIN + int'(lfsr[15:8]) % FIELD_H);
    end

    always_comb begin
        eat      = (phase == MOVE) && (body[0] == food);
        food_bad = out_of_field(food) || in_obstacle(food) ||
                   hits_body(food, body, length, 0);
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            lfsr <= `LFSR_SEED;
            grow <= 1'b0;
        end else begin
            lfsr <= {lfsr[14:0], lfsr_fb};
            grow <= eat;
        end
    end

    // retry each cycle until the cell is free
    always_ff @(posedge CLK) begin
        if (RESET) begin
            food.x <= coord_t'(`FOOD_START_X);
            food.y <= coord_t'(`FOOD_START_Y);
        end else if (eat || food_bad) begin
            food <= rnd_cell;
        end
    end

endmodule

`default_nettype wire

/* snake_game_top.sv */
`timescale 1ns/1ns
`default_nettype none

module snake_game_top import snake_pkg::*; (
    input  logic     CLK,
    input  logic     RESET,
    input  buttons_t buttons,
    input  speed_t   speed,
    input  logic     pause,
    output phase_t   phase,
    output cell_t    head,
    output cell_t    food,
    output len_t     length,
    output logic     game_over
);

    logic     step;
    logic     dead;
    logic     grow;
    heading_t heading;
    body_t    body;

    assign game_over = (phase == OVER);

    step_timer u_step_timer (
        .CLK   (CLK),
        .RESET (RESET),
        .speed (speed),
        .pause (pause),
        .step  (step)
    );

    direction_fsm u_direction_fsm (
        .CLK     (CLK),
        .RESET   (RESET),
        .step    (step),
        .dead    (dead),
        .buttons (buttons),
        .phase   (phase),
        .heading (heading)
    );

    snake_body u_snake_body (
        .CLK     (CLK),
        .RESET   (RESET),
        .step    (step),
        .grow    (grow),
        .phase   (phase),
        .heading (heading),
        .head    (head),
        .body    (body),
        .length  (length)
    );

    collision_check u_collision_check (
        .CLK    (CLK),
        .RESET  (RESET),
        .body   (body),
        .length (length),
        .dead   (dead)
    );

    food_placer u_food_placer (
        .CLK    (CLK),
        .RESET  (RESET),
        .phase  (phase),
        .body   (body),
        .length (length),
        .food   (food),
        .grow   (grow)
    );

endmodule

`default_nettype wire

/* tb_snake.sv */
`timescale 1ns/1ns
`default_nettype none
`include "snake_macros.svh"

module tb_snake import snake_pkg::*; ();

    localparam int RAND_ROUNDS  = 3;
    localparam int RAND_STEPS   = 40;
    localparam int RATE_PERIODS = 3;

    logic     CLK;
    logic     RESET;
    buttons_t buttons;
    speed_t   speed;
    logic     pause;
    phase_t   phase;
    cell_t    head;
    cell_t    food;
    len_t     length;
    logic     game_over;

    // reference model, dir 0 right 1 left 2 up 3 down
    int m_x[`SNAKE_MAX_LEN];
    int m_y[`SNAKE_MAX_LEN];
    int m_len;
    int m_phase;   // 0 idle, 1 play, 2 move, 3 over
    int m_dir;

    int          cyc = 0;
    longint      limit_ns = 0;
    logic [31:0] rnd;
    int q_btn[$];
    int q_spd[$];
    int q_pse[$];
    int q_steps[$];
    int q_hx[$];
    int q_hy[$];
    int q_len[$];
    int q_over[$];

    snake_game_top u_snake_game_top (
        .CLK       (CLK),
        .RESET     (RESET),
        .buttons   (buttons),
        .speed     (speed),
        .pause     (pause),
        .phase     (phase),
        .head      (head),
        .food      (food),
        .length    (length),
        .game_over (game_over)
    );

    initial CLK = 1'b0;
    always #50 CLK = ~CLK;
    always @(posedge CLK) cyc <= cyc + 1;

    task automatic check_value(input string name, input int got, input int exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // cycles between steps for a speed select
    function automatic int period_of(input int spd);
        int period;
        case (spd)
            0: period = `STEP_PERIOD_0;
            1: period = `STEP_PERIOD_1;
            2: period = `STEP_PERIOD_2;
            default: period = `STEP_PERIOD_3;
        endcase
        return period;
    endfunction

    // wall, obstacle, or model segments first..len-1
    function automatic int blocked(input int x, input int y, input int first);
        int hit;
        hit = 0;
        if (x < `FIELD_X_MIN || x > `FIELD_X_MAX || y < `FIELD_Y_MIN || y > `FIELD_Y_MAX) begin
            hit = 1;
        end
        if (x > -`OBST_HALF && x < `OBST_HALF && y > -`OBST_HALF && y < `OBST_HALF) begin
            hit = 1;
        end
        for (int i = first; i < m_len; i++) begin
            if (m_x[i] == x && m_y[i] == y) begin
                hit = 1;
            end
        end
        return hit;
    endfunction

    task automatic model_buttons(input int btn);
        if (m_phase == 0 && btn != 0) begin
            m_phase = 1;
        end
        if (m_phase == 1) begin
            if (btn[3] || btn[2]) begin
                m_dir = 0;   // facing right at start
            end else if (btn[1]) begin
                m_dir = 2;
            end else if (btn[0]) begin
                m_dir = 3;
            end
        end else if (m_phase == 2) begin
            if (m_dir < 2) begin
                if (btn[1]) begin
                    m_dir = 2;
                end else if (btn[0]) begin
                    m_dir = 3;
                end
            end else if (btn[3]) begin
                m_dir = 1;
            end else if (btn[2]) begin
                m_dir = 0;
            end
        end
    endtask

    task automatic model_step(input int fx, input int fy);
        int nx;
        int ny;
        if (m_phase == 1) begin
            m_phase = 2;
        end else if (m_phase == 2) begin
            nx = m_x[0];
            ny = m_y[0];
            case (m_dir)
                0: nx = nx + 1;
                1: nx = nx - 1;
                2: ny = ny + 1;
                default: ny = ny - 1;
            endcase
            // top down so old values are still there
            for (int i = `SNAKE_MAX_LEN - 1; i > 0; i--) begin
                if (i < `SNAKE_INIT_LEN || i < m_len) begin
                    m_x[i] = m_x[i-1];
                    m_y[i] = m_y[i-1];
                end else begin
                    m_x[i] = m_x[`SNAKE_INIT_LEN-1];
                    m_y[i] = m_y[`SNAKE_INIT_LEN-1];
                end
            end
            m_x[0] = nx;
            m_y[0] = ny;
            if (nx == fx && ny == fy && m_len < `SNAKE_MAX_LEN) begin
                m_len++;
            end
            if (blocked(nx, ny, 1) != 0) begin
                m_phase = 3;
            end
        end
    endtask

    task automatic compare_model();
        check_value("head_x", int'(head.x), m_x[0]);
        check_value("head_y", int'(head.y), m_y[0]);
        check_value("length", int'(length), m_len);
        check_value("phase", int'(phase), m_phase);
        check_value("game_over", int'(game_over), (m_phase == 3) ? 1 : 0);
    endtask

    task automatic do_reset();
        RESET = 1'b1;
        repeat (5) @(negedge CLK);
        RESET = 1'b0;
        for (int i = 0; i < `SNAKE_MAX_LEN; i++) begin
            m_x[i] = (i < `SNAKE_INIT_LEN) ? 4 - i : 0;
            m_y[i] = -3;
        end
        m_len   = `SNAKE_INIT_LEN;
        m_phase = 0;
        m_dir   = 0;
        check_value("food_x", int'(food.x), `FOOD_START_X);
        check_value("food_y", int'(food.y), `FOOD_START_Y);
        compare_model();
    endtask

    // steps counted over whole periods right after reset
    task automatic check_step_rate(input int spd, input int periods);
        int seen;
        int window;
        window  = periods * (period_of(spd) + 1);
        buttons = '0;
        speed   = speed_t'(spd[1:0]);
        pause   = 1'b0;
        do_reset();
        seen = 0;
        repeat (window) begin
            @(negedge CLK);
            if (u_snake_game_top.step) begin
                seen++;
            end
        end
        check_value("step_count", seen, window / (period_of(spd) + 1));
    endtask

    // called right after a falling edge
    task automatic run_row(input int btn, input int spd, input int pse, input int nsteps);
        int seen;
        int prev;
        int period;
        period  = period_of(spd);
        buttons = buttons_t'(btn[3:0]);
        speed   = speed_t'(spd[1:0]);
        pause   = pse[0];
        model_buttons(btn);
        seen = 0;
        prev = -1;
        if (pse != 0) begin
            repeat (nsteps * (period + 1)) begin
                @(negedge CLK);
                if (u_snake_game_top.step) seen++;
            end
            check_value("paused_steps", seen, 0);
        end else begin
            while (seen < nsteps) begin
                @(negedge CLK);
                if (u_snake_game_top.step) begin
                    if (prev >= 0) begin
                        check_value("step_gap", cyc - prev, period + 1);
                    end
                    prev = cyc;
                    seen++;
                    check_value("food_blocked", blocked(int'(food.x), int'(food.y), 0), 0);
                    model_step(int'(food.x), int'(food.y));
                end
            end
            repeat (3) @(negedge CLK);   // settle
        end
        compare_model();
    endtask

    initial begin
        wait (limit_ns > 0);
        #(limit_ns);
        $display("watchdog timeout, the run took longer than the tests allow");
        $display("CHECKS FAILED");
        $fatal(1);
    end

    initial begin
        int    fd;
        int    total;
        int    b, s, p, n, hx, hy, ln, ov;
        int    sel;
        string line;
        RESET   = 1'b1;
        buttons = '0;
        speed   = 2'd3;
        pause   = 1'b0;
        rnd     = 32'hca6a;
        fd = $fopen("snake_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open snake_stimulus.txt");
            $display("CHECKS FAILED");
            $fatal(1);
        end
        total = RAND_ROUNDS * RAND_STEPS + 4 * RATE_PERIODS;
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line[0] != "#" &&
                $sscanf(line, "%h %d %d %d %d %d %d %d", b, s, p, n, hx, hy, ln, ov) == 8) begin
                q_btn.push_back(b);
                q_spd.push_back(s);
                q_pse.push_back(p);
                q_steps.push_back(n);
                q_hx.push_back(hx);
                q_hy.push_back(hy);
                q_len.push_back(ln);
                q_over.push_back(ov);
                total += n;
            end
        end
        $fclose(fd);
        limit_ns = 200 * longint'(total * (`STEP_PERIOD_0 + 4) +
                                  (q_btn.size() + RAND_ROUNDS + 4) * 10);

        @(negedge CLK);
        foreach (q_btn[k]) begin
            if (q_steps[k] == 0) begin
                buttons = '0;
                speed   = speed_t'(q_spd[k]);
                pause   = 1'b0;
                do_reset();
            end else begin
                run_row(q_btn[k], q_spd[k], q_pse[k], q_steps[k]);
            end
            check_value("row_head_x", int'(head.x), q_hx[k]);
            check_value("row_head_y", int'(head.y), q_hy[k]);
            check_value("row_length", int'(length), q_len[k]);
            check_value("row_game_over", int'(game_over), q_over[k]);
        end

        // step rate for every speed select
        for (int sp = 0; sp < 4; sp++) begin
            check_step_rate(sp, RATE_PERIODS);
        end

        // random turns, one step each
        for (int r = 0; r < RAND_ROUNDS; r++) begin
            buttons = '0;
            speed   = 2'd3;
            pause   = 1'b0;
            do_reset();
            for (int i = 0; i < RAND_STEPS && m_phase != 3; i++) begin
                rnd = xorshift(rnd);
                sel = int'(rnd % 6);
                case (sel)
                    2: run_row(8, 3, 0, 1);
                    3: run_row(4, 3, 0, 1);
                    4: run_row(2, 3, 0, 1);
                    5: run_row(1, 3, 0, 1);
                    default: run_row(0, 3, 0, 1);
                endcase
            end
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* snake_stimulus.txt */
# buttons(hex: left=8 right=4 up=2 down=1) speed pause steps head_x head_y length game_over
# steps 0 applies reset, a pause row holds for that many step periods
0 3 0 0 4 -3 5 0
0 3 0 2 4 -3 5 0
8 3 0 3 6 -3 6 0
8 0 0 1 7 -3 6 0
1 1 0 2 7 -5 6 0
8 2 0 2 5 -5 6 0
0 2 1 2 5 -5 6 0
2 3 0 1 5 -4 6 0
4 3 0 1 6 -4 6 0
1 3 0 1 6 -5 6 1
2 3 0 2 6 -5 6 1
# wall hit going up
0 3 0 0 4 -3 5 0
2 3 0 12 4 8 5 1
8 3 0 2 4 8 5 1
# obstacle hit
0 2 0 0 4 -3 5 0
2 2 0 3 4 -1 5 0
8 2 0 3 1 -1 5 1

/* tb.f */
+incdir+.
snake_pkg.sv
step_timer.sv
direction_fsm.sv
snake_body.sv
collision_check.sv
food_placer.sv
snake_game_top.sv
tb_snake.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench, exit status gives pass or fail
cd "$(dirname "$0")" \
    && verilator --binary --timing --timescale 1ns/1ns --top-module tb_snake \
        -f tb.f -o tb_snake_sim \
    && ./obj_dir/tb_snake_sim \
    || { echo "simulation failed"; exit 1; }
